// ==== list.f ====
hdl/board_pkg.sv
hdl/sample_tick_gen.sv
hdl/key_debouncer.sv
hdl/board_wb_regs.sv
hdl/seven_seg_scanner.sv
hdl/board_io_top.sv
verif/board_io_tb.sv

// ==== verif/board_io_tb.sv ====
`timescale 1ns/10ps

module board_io_tb;

    import board_pkg::*;

    //----------------------------------------
    // Timing limits
    //----------------------------------------

    localparam int clk_period = 100;
    // Cycles from request to ack before the bus is declared dead
    localparam int ack_bound  = 4;
    // Two sync flops plus debounce_ticks + 1 sampling ticks
    localparam int key_bound  = 2 + (debounce_ticks + 1) * tick_div;
    localparam int key_margin = 8;
    // Room for one full trip around the display
    localparam int scan_bound = 2 * w_digit * tick_div;
    // Scan rows are the slowest, two waits per digit
    localparam int row_bound  = 2 * w_digit * scan_bound;

    // Reference segment patterns, a in bit 7, h off
    localparam logic [7:0] seg_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    typedef enum logic [2:0]
    {
        op_write,
        op_read,
        op_keys,
        op_glitch,
        op_scan,
        op_led
    }
    test_op_e;

    // One step of the stimulus table
    typedef struct packed
    {
        test_op_e    op;
        reg_addr_e   adr;
        logic [31:0] dat;
        logic [31:0] exp;
    }
    test_row_t;

    logic               clk;
    logic               reset;
    logic [w_key - 1:0] key_n;
    wb_req_t            wb_req;
    wb_rsp_t            wb_rsp;
    logic [w_led - 1:0] led;
    logic [7:0]         abcdefgh;
    logic [w_digit - 1:0] digit;

    test_row_t          rows [$];

    board_io_top dut
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .key_n    ( key_n    ),
        .wb_req   ( wb_req   ),
        .wb_rsp   ( wb_rsp   ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~ clk;
    end

    //----------------------------------------
    // Failure handling and compares
    //----------------------------------------

    task automatic stop_with_failure ();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_problem (input string msg);
        $display("%s at %0t", msg, $time);
        stop_with_failure();
    endtask

    task automatic check_rsp_dat (input wb_rsp_t rsp, input logic [31:0] exp, input string what);
        if (rsp.dat !== exp)
        begin
            $display("MISMATCH at %0t: %s returned 0x%08h, expected 0x%08h",
                     $time, what, rsp.dat, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_led (input logic [w_led - 1:0] got, input logic [w_led - 1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_select (input logic [w_digit - 1:0] got,
                                 input logic [w_digit - 1:0] exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_segments (input logic [7:0] got, input logic [7:0] exp,
                                   input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s shows %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    //----------------------------------------
    // Bus and key drivers
    //----------------------------------------

    // Request held until ack, sampled on the falling edge
    task automatic wb_access (input logic we, input reg_addr_e adr, input logic [31:0] dat,
                              output wb_rsp_t rsp);
        int waited;
        waited = 0;
        @ (negedge clk);
        wb_req = '{ cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat };
        @ (negedge clk);
        while (! wb_rsp.ack)
        begin
            waited++;
            if (waited >= ack_bound)
                report_problem("Wishbone ack did not arrive within 4 cycles");
            @ (negedge clk);
        end
        rsp    = wb_rsp;
        wb_req = '0;
    endtask

    // Hold a key pattern long enough to be accepted
    task automatic apply_keys (input logic [w_key - 1:0] pressed);
        @ (negedge clk);
        key_n = ~ pressed;
        repeat (key_bound + key_margin)
            @ (negedge clk);
    endtask

    // Pulse shorter than one sampling period
    task automatic pulse_keys (input logic [w_key - 1:0] pressed);
        @ (negedge clk);
        key_n = ~ pressed;
        repeat (tick_div - 1)
            @ (negedge clk);
        key_n = '1;
        repeat (key_bound + key_margin)
            @ (negedge clk);
    endtask

    task automatic wait_for_select (input logic [w_digit - 1:0] sel, input logic want_equal);
        int waited;
        waited = 0;
        @ (negedge clk);
        while ((digit == sel) != want_equal)
        begin
            waited++;
            if (waited >= scan_bound)
                report_problem("Digit scanner stopped advancing");
            @ (negedge clk);
        end
    endtask

    // Catch each digit on the cycle it becomes active
    task automatic scan_digits (input logic [31:0] value);
        logic [w_digit - 1:0] sel;
        for (int k = 0; k < w_digit; k++)
        begin
            sel = w_digit'(1) << k;
            wait_for_select(sel, 1'b0);
            wait_for_select(sel, 1'b1);
            check_segments(abcdefgh, seg_table[value[k * 4 +: 4]],
                           $sformatf("digit %0d", k));
        end
    endtask

    task automatic add_row (input test_op_e op, input reg_addr_e adr, input logic [31:0] dat,
                            input logic [31:0] exp);
        rows.push_back('{ op: op, adr: adr, dat: dat, exp: exp });
    endtask

    task automatic watchdog ();
        #((rows.size() + 1) * row_bound * clk_period);
        $display("Watchdog expired, the run took too long");
        $display("TEST FAIL");
        $fatal(1);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------

    initial
    begin
        wb_rsp_t     rsp;
        logic [7:0]  rnd_led;
        logic [31:0] rnd_dig;

        reset      = 1'b1;
        key_n      = '1;
        wb_req     = '0;

        void'($urandom(56));
        rnd_led = 8'($urandom);
        rnd_dig = $urandom;

        // Reset values
        add_row(op_read,   reg_key_state,  32'h0,   32'h0);
        add_row(op_read,   reg_key_events, 32'h0,   32'h0);
        add_row(op_read,   reg_led,        32'h0,   32'h0);
        add_row(op_read,   reg_digits,     32'h0,   32'h0);
        // LED write and readback
        add_row(op_write,  reg_led,        32'(rnd_led), 32'h0);
        add_row(op_led,    reg_led,        32'h0,   32'(rnd_led));
        add_row(op_read,   reg_led,        32'h0,   32'(rnd_led));
        // Press, then release, events stay
        add_row(op_keys,   reg_key_state,  32'h25,  32'h0);
        add_row(op_read,   reg_key_state,  32'h0,   32'h25);
        add_row(op_read,   reg_key_events, 32'h0,   32'h25);
        add_row(op_keys,   reg_key_state,  32'h00,  32'h0);
        add_row(op_read,   reg_key_state,  32'h0,   32'h00);
        add_row(op_read,   reg_key_events, 32'h0,   32'h25);
        // Short pulses must be ignored
        add_row(op_glitch, reg_key_state,  32'hda,  32'h0);
        add_row(op_read,   reg_key_state,  32'h0,   32'h00);
        add_row(op_read,   reg_key_events, 32'h0,   32'h25);
        // Write one to clear bits 0 and 2
        add_row(op_write,  reg_key_events, 32'h05,  32'h0);
        add_row(op_read,   reg_key_events, 32'h0,   32'h20);
        // Display contents
        add_row(op_write,  reg_digits,     rnd_dig, 32'h0);
        add_row(op_scan,   reg_digits,     rnd_dig, 32'h0);
        add_row(op_read,   reg_digits,     32'h0,   rnd_dig);

        fork
            watchdog();
        join_none

        repeat (3)
            @ (posedge clk);
        @ (negedge clk);
        reset = 1'b0;

        check_led(led, '0, "LED output after reset");
        check_select(digit, w_digit'(1), "Digit select after reset");
        check_segments(abcdefgh, seg_table[0], "Segments after reset");

        foreach (rows[i])
        begin
            case (rows[i].op)
                op_write  : wb_access(1'b1, rows[i].adr, rows[i].dat, rsp);
                op_read   :
                begin
                    wb_access(1'b0, rows[i].adr, 32'h0, rsp);
                    check_rsp_dat(rsp, rows[i].exp,
                                  $sformatf("row %0d read of %s", i, rows[i].adr.name()));
                end
                op_keys   : apply_keys(rows[i].dat[w_key - 1:0]);
                op_glitch : pulse_keys(rows[i].dat[w_key - 1:0]);
                op_led    : check_led(led, rows[i].exp[w_led - 1:0], "LED output");
                op_scan   : scan_digits(rows[i].dat);
                default   : report_problem("Unknown operation in stimulus table");
            endcase
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== hdl/board_io_top.sv ====
`timescale 1ns/10ps

module board_io_top
(
    input  logic                            clk,
    input  logic                            reset,

    // Raw board keys, low while pressed
    input  logic [board_pkg::w_key   - 1:0] key_n,

    input  board_pkg::wb_req_t              wb_req,
    output board_pkg::wb_rsp_t              wb_rsp,

    output logic [board_pkg::w_led   - 1:0] led,
    output logic [                    7:0]  abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit
);

    import board_pkg::*;

    logic        tick;
    key_status_t key_status [w_key];
    logic [31:0] digits;

    //----------------------------------------
    // Shared sampling tick
    //----------------------------------------

    sample_tick_gen i_sample_tick_gen
    (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .tick   ( tick   )
    );

    //----------------------------------------
    // One debouncer per key
    //----------------------------------------

    generate
        for (genvar i = 0; i < w_key; i ++)
        begin : key_deb
            key_debouncer i_key_debouncer
            (
                .clk    ( clk            ),
                .reset  ( reset          ),
                .tick   ( tick           ),
                .key_n  ( key_n      [i] ),
                .status ( key_status [i] )
            );
        end
    endgenerate

    // Host registers
    board_wb_regs i_board_wb_regs
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .wb_req     ( wb_req     ),
        .wb_rsp     ( wb_rsp     ),
        .key_status ( key_status ),
        .led        ( led        ),
        .digits     ( digits     )
    );

    // Display multiplexing
    seven_seg_scanner i_seven_seg_scanner
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .tick     ( tick     ),
        .digits   ( digits   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

// ==== hdl/seven_seg_scanner.sv ====
`timescale 1ns/10ps

module seven_seg_scanner
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            tick,
    input  logic [                   31:0]  digits,
    output logic [                    7:0]  abcdefgh,
    output logic [board_pkg::w_digit - 1:0] digit
);

    import board_pkg::*;

    // Digit currently being driven
    logic [w_digit_idx - 1:0] index;
    logic [              3:0] nibble;

    //----------------------------------------
    // Hex to segments, a in bit 7, h off
    //----------------------------------------

    function automatic logic [7:0] hex_to_segments (input logic [3:0] hex);
        case (hex)
            4'h0 : return 8'b1111_1100;
            4'h1 : return 8'b0110_0000;
            4'h2 : return 8'b1101_1010;
            4'h3 : return 8'b1111_0010;
            4'h4 : return 8'b0110_0110;
            4'h5 : return 8'b1011_0110;
            4'h6 : return 8'b1011_1110;
            4'h7 : return 8'b1110_0000;
            4'h8 : return 8'b1111_1110;
            4'h9 : return 8'b1111_0110;
            4'ha : return 8'b1110_1110;
            4'hb : return 8'b0011_1110;
            4'hc : return 8'b1001_1100;
            4'hd : return 8'b0111_1010;
            4'he : return 8'b1001_1110;
            default : return 8'b1000_1110;
        endcase
    endfunction

    //----------------------------------------
    // Scan index
    //----------------------------------------

    always_ff @ (posedge clk)
    begin
        if (reset)
            index <= '0;
        else if (tick)
            index <= (index == w_digit_idx' (w_digit - 1)) ? '0 : index + 1'b1;
    end

    assign nibble = digits [index * 4 +: 4];

    // Select and pattern are registered together
    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            digit    <= w_digit' (1);
            abcdefgh <= hex_to_segments (4'h0);
        end
        else
        begin
            digit    <= w_digit' (1) << index;
            abcdefgh <= hex_to_segments (nibble);
        end
    end

    // Exactly one digit lit at all times
    digit_one_hot : assert property
    (
        @ (posedge clk) disable iff (reset)
        $onehot (digit)
    )
    else
        $error ("Digit select is not one-hot");

endmodule

// ==== hdl/board_wb_regs.sv ====
`timescale 1ns/10ps

module board_wb_regs
(
    input  logic                            clk,
    input  logic                            reset,

    input  board_pkg::wb_req_t              wb_req,
    output board_pkg::wb_rsp_t              wb_rsp,

    input  board_pkg::key_status_t          key_status [board_pkg::w_key],

    output logic [board_pkg::w_led - 1:0]   led,
    output logic [                 31:0]    digits
);

    import board_pkg::*;

    logic               ack;
    logic               req;
    logic               wr_en;
    logic               rd_en;

    // Read path
    logic [31:0]        rd_mux;
    logic [31:0]        rd_dat;

    // Flattened debouncer outputs
    logic [w_key - 1:0] key_state;
    logic [w_key - 1:0] key_press;

    // Sticky press events and their write-one-to-clear mask
    logic [w_key - 1:0] events;
    logic [w_key - 1:0] clear_mask;

    //----------------------------------------
    // Key status unpacking
    //----------------------------------------

    always_comb
    begin
        for (int i = 0; i < w_key; i ++)
        begin
            key_state [i] = key_status [i].level;
            key_press [i] = key_status [i].press;
        end
    end

    //----------------------------------------
    // Bus handshake
    //----------------------------------------

    // New request only while no ack is out
    assign req   = wb_req.cyc & wb_req.stb & ~ ack;
    assign wr_en = req &   wb_req.we;
    assign rd_en = req & ~ wb_req.we;

    always_ff @ (posedge clk)
    begin
        if (reset)
            ack <= 1'b0;
        else
            ack <= req;
    end

    //----------------------------------------
    // Read mux
    //----------------------------------------

    always_comb
    begin
        case (wb_req.adr)
            reg_key_state  : rd_mux = 32' (key_state);
            reg_key_events : rd_mux = 32' (events);
            reg_led        : rd_mux = 32' (led);
            reg_digits     : rd_mux = digits;
            default        : rd_mux = '0;
        endcase
    end

    // Captured on the same edge that raises ack
    always_ff @ (posedge clk)
    begin
        if (rd_en)
            rd_dat <= rd_mux;
    end

    assign wb_rsp = '{ ack: ack, dat: rd_dat };

    //----------------------------------------
    // Writable registers
    //----------------------------------------

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            led    <= '0;
            digits <= '0;
        end
        else if (wr_en)
        begin
            case (wb_req.adr)
                reg_led    : led    <= wb_req.dat [w_led - 1:0];
                reg_digits : digits <= wb_req.dat;
                // Key state is read-only, events handled below
                default    : ;
            endcase
        end
    end

    //----------------------------------------
    // Event register
    //----------------------------------------

    always_comb
    begin
        if (wr_en && wb_req.adr == reg_key_events)
            clear_mask = wb_req.dat [w_key - 1:0];
        else
            clear_mask = '0;
    end

    // Set after clear so a same-cycle press is kept
    always_ff @ (posedge clk)
    begin
        if (reset)
            events <= '0;
        else
            events <= (events & ~ clear_mask) | key_press;
    end

    //----------------------------------------
    // Checks
    //----------------------------------------

    // One request gives exactly one ack cycle
    ack_single_cycle : assert property
    (
        @ (posedge clk) disable iff (reset)
        ack |=> ! ack
    )
    else
        $error ("Wishbone ack high on two consecutive cycles");

endmodule

// ==== hdl/key_debouncer.sv ====
`timescale 1ns/10ps

module key_debouncer
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,
    input  logic                   key_n,
    output board_pkg::key_status_t status
);

    import board_pkg::*;

    // Synchronizer stages, already inverted to pressed-high
    logic                   sync_0;
    logic                   sync_1;

    // Run of samples that disagree with the accepted level
    logic [w_deb_cnt - 1:0] cnt;

    logic                   key_level;
    logic                   key_press;

    //----------------------------------------
    // Synchronizer
    //----------------------------------------

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            // Released after reset
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end
        else
        begin
            sync_0 <= ~ key_n;
            sync_1 <= sync_0;
        end
    end

    //----------------------------------------
    // Debounce counter
    //----------------------------------------

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            cnt       <= '0;
            key_level <= 1'b0;
            key_press <= 1'b0;
        end
        else
        begin
            // Press is a single-cycle pulse
            key_press <= 1'b0;

            if (tick)
            begin
                if (sync_1 == key_level)
                    cnt <= '0;
                else if (cnt == w_deb_cnt' (debounce_ticks - 1))
                begin
                    // Enough agreeing samples so accept the new level
                    cnt       <= '0;
                    key_level <= sync_1;
                    key_press <= sync_1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    assign status = '{ level: key_level, press: key_press };

endmodule

// ==== hdl/sample_tick_gen.sv ====
`timescale 1ns/10ps

module sample_tick_gen
(
    input  logic clk,
    input  logic reset,
    output logic tick
);

    import board_pkg::*;

    // Free-running divider state
    logic [w_tick_cnt - 1:0] cnt;

    //----------------------------------------
    // Clock enable in place of a slow clock
    //----------------------------------------

    always_ff @ (posedge clk)
    begin
        if (reset)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == w_tick_cnt' (tick_div - 1))
        begin
            // Wrap and fire for one cycle
            cnt  <= '0;
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== hdl/board_pkg.sv ====
package board_pkg;

    //----------------------------------------
    // Board dimensions
    //----------------------------------------

    localparam int w_key   = 8;
    localparam int w_led   = 8;
    localparam int w_digit = 8;

    // Clock cycles per sampling tick
    localparam int tick_div       = 4;
    // Equal samples needed before a key level is accepted
    localparam int debounce_ticks = 3;

    // Counter widths derived from the above
    localparam int w_tick_cnt  = $clog2 (tick_div);
    localparam int w_deb_cnt   = $clog2 (debounce_ticks + 1);
    localparam int w_digit_idx = $clog2 (w_digit);

    //----------------------------------------
    // Register map and bus types
    //----------------------------------------

    // Word addresses of the Wishbone register block
    typedef enum logic [1:0]
    {
        reg_key_state  = 2'd0,
        reg_key_events = 2'd1,
        reg_led        = 2'd2,
        reg_digits     = 2'd3
    }
    reg_addr_e;

    // Master to slave
    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        reg_addr_e   adr;
        logic [31:0] dat;
    }
    wb_req_t;

    // Slave to master
    typedef struct packed
    {
        logic        ack;
        logic [31:0] dat;
    }
    wb_rsp_t;

    // Debounced state of one key
    typedef struct packed
    {
        logic level;
        logic press;
    }
    key_status_t;

endpackage
